// ==== hw/exe_pkg.sv ====
package exe_pkg;

    // alu opcodes, only OP_ADD and OP_SUB trap on overflow
    typedef enum logic [3:0] {
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RS,
        SRC1_SA,
        SRC1_PC
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RT,
        SRC2_SIMM,
        SRC2_ZIMM,
        SRC2_EIGHT
    } src2_sel_e;

    // one decoded instruction from decode
    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     alu_op;
        src1_sel_e   src1_sel;
        src2_sel_e   src2_sel;
        logic [15:0] imm;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [4:0]  dest;
        logic        gr_we;
        logic        ds_except;
        logic [4:0]  ds_exccode;
    } exe_slot_in_t;

    // dep flags mark inst2 sources written by inst1
    typedef struct packed {
        logic         inst2_valid;
        logic         dep_rs;
        logic         dep_rt;
        exe_slot_in_t slot1;
        exe_slot_in_t slot2;
    } exe_pair_in_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [31:0] mem_addr;
        logic        except;
        logic [4:0]  exccode;
        logic [31:0] badvaddr;
        logic [4:0]  dest;
        logic        gr_we;
        // store data
        logic [31:0] rt_value;
    } exe_slot_out_t;

    typedef struct packed {
        logic          inst2_valid;
        exe_slot_out_t slot1;
        exe_slot_out_t slot2;
    } exe_pair_out_t;

    localparam logic [4:0] EXC_OV = 5'd12;

endpackage

// ==== hw/exe_alu.sv ====
`timescale 1ns/100ps

module exe_alu (
    input  exe_pkg::alu_op_e op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    output logic [31:0]      result,
    output logic             overflow
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shamt;
    logic        add_ovf;
    logic        sub_ovf;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src1[4:0];

    // signed overflow, operand signs vs result sign
    assign add_ovf = (src1[31] == src2[31]) && (sum[31] != src1[31]);
    assign sub_ovf = (src1[31] != src2[31]) && (diff[31] != src1[31]);

    assign overflow = ((op == exe_pkg::OP_ADD) && add_ovf) ||
                      ((op == exe_pkg::OP_SUB) && sub_ovf);

    always_comb begin
        case (op)
            exe_pkg::OP_ADD,
            exe_pkg::OP_ADDU: begin
                result = sum;
            end
            exe_pkg::OP_SUB,
            exe_pkg::OP_SUBU: begin
                result = diff;
            end
            exe_pkg::OP_SLT: begin
                result = {31'd0, $signed(src1) < $signed(src2)};
            end
            exe_pkg::OP_SLTU: begin
                result = {31'd0, src1 < src2};
            end
            exe_pkg::OP_AND: result = src1 & src2;
            exe_pkg::OP_OR:  result = src1 | src2;
            exe_pkg::OP_XOR: result = src1 ^ src2;
            exe_pkg::OP_NOR: result = ~(src1 | src2);
            // shift amount comes from src1, value from src2
            exe_pkg::OP_SLL: result = src2 << shamt;
            exe_pkg::OP_SRL: result = src2 >> shamt;
            exe_pkg::OP_SRA: result = $unsigned($signed(src2) >>> shamt);
            exe_pkg::OP_LUI: result = {src2[15:0], 16'd0};
            default: begin
                result = 32'd0;
            end
        endcase
    end

endmodule

// ==== hw/exe_lane.sv ====
`timescale 1ns/100ps

module exe_lane (
    input  exe_pkg::exe_slot_in_t  slot,
    input  logic                   use_rs_bypass,
    input  logic                   use_rt_bypass,
    input  logic [31:0]            rs_bypass,
    input  logic [31:0]            rt_bypass,
    output exe_pkg::exe_slot_out_t out
);

    logic [31:0] rs;
    logic [31:0] rt;
    logic [31:0] simm;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] result;
    logic [31:0] mem_addr;
    logic        overflow;

    // register values, replaced by inst1 result on a dependency
    assign rs   = use_rs_bypass ? rs_bypass : slot.rs_value;
    assign rt   = use_rt_bypass ? rt_bypass : slot.rt_value;
    assign simm = {{16{slot.imm[15]}}, slot.imm};

    always_comb begin
        case (slot.src1_sel)
            exe_pkg::SRC1_SA: src1 = {27'd0, slot.imm[10:6]};
            exe_pkg::SRC1_PC: src1 = slot.pc;
            default:          src1 = rs;
        endcase
    end

    always_comb begin
        case (slot.src2_sel)
            exe_pkg::SRC2_SIMM:  src2 = simm;
            exe_pkg::SRC2_ZIMM:  src2 = {16'd0, slot.imm};
            exe_pkg::SRC2_EIGHT: src2 = 32'd8;
            default:             src2 = rt;
        endcase
    end

    assign mem_addr = rs + simm;

    exe_alu u_alu (
        .op       (slot.alu_op),
        .src1     (src1),
        .src2     (src2),
        .result   (result),
        .overflow (overflow)
    );

    always_comb begin
        out.pc       = slot.pc;
        out.result   = result;
        out.mem_addr = mem_addr;
        out.except   = slot.ds_except | overflow;
        // decode exception wins over overflow
        if (slot.ds_except) begin
            out.exccode  = slot.ds_exccode;
            out.badvaddr = slot.pc;
        end else begin
            out.exccode  = overflow ? exe_pkg::EXC_OV : 5'd0;
            out.badvaddr = mem_addr;
        end
        out.dest     = slot.dest;
        out.gr_we    = slot.gr_we;
        out.rt_value = rt;
    end

endmodule

// ==== hw/exe_pair_ctrl.sv ====
`timescale 1ns/100ps

module exe_pair_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  exe_pkg::exe_pair_in_t in_bus,
    input  logic                  out_allowin,
    input  logic                  clear,
    input  logic [31:0]           slot1_result,
    output logic                  allowin,
    output logic                  out_valid,
    output exe_pkg::exe_pair_in_t pair,
    output logic                  use_rs_bypass,
    output logic                  use_rt_bypass,
    output logic [31:0]           rs_bypass,
    output logic [31:0]           rt_bypass
);

    logic valid;
    logic stall;
    logic has_dep;
    logic ready_go;

    assign use_rs_bypass = pair.inst2_valid & pair.dep_rs;
    assign use_rt_bypass = pair.inst2_valid & pair.dep_rt;
    assign has_dep       = use_rs_bypass | use_rt_bypass;

    // a dependent pair waits one cycle for the bypass registers
    assign ready_go  = ~has_dep | stall;
    assign allowin   = ~valid | (ready_go & out_allowin);
    assign out_valid = (valid & ready_go) | clear;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (clear) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin && !clear) begin
            pair <= in_bus;
        end
    end

    // stall stays set until the pair leaves, so back-pressure holds out_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            stall <= 1'b0;
        end else if (clear) begin
            stall <= 1'b0;
        end else if (valid && has_dep && !stall) begin
            stall <= 1'b1;
        end else if (stall && out_allowin) begin
            stall <= 1'b0;
        end
    end

    // capture inst1 result in the first cycle of a dependent pair
    always_ff @(posedge clk) begin
        if (valid && !stall) begin
            if (use_rs_bypass) begin
                rs_bypass <= slot1_result;
            end
            if (use_rt_bypass) begin
                rt_bypass <= slot1_result;
            end
        end
    end

    // stall only ever belongs to a held dependent pair
    a_stall_dep: assert property (@(posedge clk) disable iff (reset)
        stall |-> (valid && has_dep));

    a_hold_pair: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_allowin) |=> $stable(pair));

endmodule

// ==== hw/exe_stage.sv ====
`timescale 1ns/100ps

module exe_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  exe_pkg::exe_pair_in_t  in_bus,
    output logic                   allowin,
    output logic                   out_valid,
    output exe_pkg::exe_pair_out_t out_bus,
    input  logic                   out_allowin,
    input  logic                   clear
);

    exe_pkg::exe_pair_in_t  pair;
    exe_pkg::exe_slot_out_t lane1_out;
    exe_pkg::exe_slot_out_t lane2_out;
    logic                   use_rs_bypass;
    logic                   use_rt_bypass;
    logic [31:0]            rs_bypass;
    logic [31:0]            rt_bypass;

    exe_pair_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_bus        (in_bus),
        .out_allowin   (out_allowin),
        .clear         (clear),
        .slot1_result  (lane1_out.result),
        .allowin       (allowin),
        .out_valid     (out_valid),
        .pair          (pair),
        .use_rs_bypass (use_rs_bypass),
        .use_rt_bypass (use_rt_bypass),
        .rs_bypass     (rs_bypass),
        .rt_bypass     (rt_bypass)
    );

    // inst1 never depends on anything inside the pair
    exe_lane u_lane1 (
        .slot          (pair.slot1),
        .use_rs_bypass (1'b0),
        .use_rt_bypass (1'b0),
        .rs_bypass     (32'd0),
        .rt_bypass     (32'd0),
        .out           (lane1_out)
    );

    exe_lane u_lane2 (
        .slot          (pair.slot2),
        .use_rs_bypass (use_rs_bypass),
        .use_rt_bypass (use_rt_bypass),
        .rs_bypass     (rs_bypass),
        .rt_bypass     (rt_bypass),
        .out           (lane2_out)
    );

    assign out_bus = '{
        inst2_valid: pair.inst2_valid,
        slot1:       lane1_out,
        slot2:       lane2_out
    };

endmodule

// ==== tests/tb_exe_model.svh ====
`ifndef TB_EXE_MODEL_SVH
`define TB_EXE_MODEL_SVH

logic [31:0] rng_state = 32'h282d;

// lcg step, the upper half is the usable part
function automatic logic [15:0] rand16();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
endfunction

function automatic int unsigned pick(int unsigned n);
    return 32'(rand16()) % n;
endfunction

// returns {overflow, result}
function automatic logic [32:0] alu_model(exe_pkg::alu_op_e op, logic [31:0] a,
                                          logic [31:0] b);
    logic [32:0] wide;
    logic [31:0] res;
    logic        ovf;
    // 33 bit signed sum or difference, overflow when the top two bits differ
    wide = {a[31], a} + {b[31], b};
    if (op == exe_pkg::OP_SUB || op == exe_pkg::OP_SUBU) begin
        wide = {a[31], a} - {b[31], b};
    end
    ovf = (op == exe_pkg::OP_ADD || op == exe_pkg::OP_SUB) && (wide[32] != wide[31]);
    res = wide[31:0];
    case (op)
        exe_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exe_pkg::OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
        exe_pkg::OP_AND:  res = a & b;
        exe_pkg::OP_OR:   res = a | b;
        exe_pkg::OP_XOR:  res = a ^ b;
        exe_pkg::OP_NOR:  res = ~(a | b);
        exe_pkg::OP_SLL:  res = b << a[4:0];
        exe_pkg::OP_SRL:  res = b >> a[4:0];
        exe_pkg::OP_SRA: begin
            res = b;
            for (int i = 0; i < int'(a[4:0]); i++) begin
                res = {res[31], res[31:1]};
            end
        end
        exe_pkg::OP_LUI:  res = {b[15:0], 16'd0};
        default: ;
    endcase
    return {ovf, res};
endfunction

function automatic exe_pkg::exe_slot_out_t slot_model(exe_pkg::exe_slot_in_t s,
                                                      logic [31:0] rs, logic [31:0] rt);
    exe_pkg::exe_slot_out_t o;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ext;
    logic [32:0] alu;
    ext = {{16{s.imm[15]}}, s.imm};
    case (s.src1_sel)
        exe_pkg::SRC1_SA: a = {27'd0, s.imm[10:6]};
        exe_pkg::SRC1_PC: a = s.pc;
        default:          a = rs;
    endcase
    case (s.src2_sel)
        exe_pkg::SRC2_SIMM:  b = ext;
        exe_pkg::SRC2_ZIMM:  b = {16'd0, s.imm};
        exe_pkg::SRC2_EIGHT: b = 32'd8;
        default:             b = rt;
    endcase
    alu = alu_model(s.alu_op, a, b);
    o.pc       = s.pc;
    o.result   = alu[31:0];
    o.mem_addr = rs + ext;
    o.except   = s.ds_except | alu[32];
    o.exccode  = s.ds_except ? s.ds_exccode : (alu[32] ? exe_pkg::EXC_OV : 5'd0);
    o.badvaddr = s.ds_except ? s.pc : o.mem_addr;
    o.dest     = s.dest;
    o.gr_we    = s.gr_we;
    o.rt_value = rt;
    return o;
endfunction

// inst2 sees inst1's result in place of a flagged source
function automatic exe_pkg::exe_pair_out_t pair_model(exe_pkg::exe_pair_in_t p);
    exe_pkg::exe_pair_out_t o;
    logic [31:0] rs2;
    logic [31:0] rt2;
    o.inst2_valid = p.inst2_valid;
    o.slot1 = slot_model(p.slot1, p.slot1.rs_value, p.slot1.rt_value);
    rs2 = (p.inst2_valid && p.dep_rs) ? o.slot1.result : p.slot2.rs_value;
    rt2 = (p.inst2_valid && p.dep_rt) ? o.slot1.result : p.slot2.rt_value;
    o.slot2 = slot_model(p.slot2, rs2, rt2);
    return o;
endfunction

`endif

// ==== tests/tb_exe_stage.sv ====
`timescale 1ns/100ps

module tb_exe_stage;

    localparam int NUM_PAIRS  = 2000;
    localparam int MAX_CYCLES = 20000;
    localparam int MAX_IDLE   = 100;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   in_valid;
    exe_pkg::exe_pair_in_t  in_bus;
    logic                   allowin;
    logic                   out_valid;
    exe_pkg::exe_pair_out_t out_bus;
    logic                   out_allowin;
    logic                   clear;

    // one-entry expected slot, the stage holds at most one pair
    exe_pkg::exe_pair_out_t expected;
    logic                   pending = 1'b0;
    int                     accept_cycle = 0;
    int                     latency = 1;
    int                     cycle = 0;
    int                     pairs_done = 0;
    int                     idle = 0;

    `include "tb_exe_model.svh"

    exe_stage UUT (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .allowin     (allowin),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .out_allowin (out_allowin),
        .clear       (clear)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] exp_value);
        if (actual !== exp_value) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp_value, actual);
            stop_run();
        end
    endtask

    task automatic check_slot(input string name, input exe_pkg::exe_slot_out_t act,
                              input exe_pkg::exe_slot_out_t exp_slot);
        check_value({name, ".pc"}, act.pc, exp_slot.pc);
        check_value({name, ".result"}, act.result, exp_slot.result);
        check_value({name, ".mem_addr"}, act.mem_addr, exp_slot.mem_addr);
        check_value({name, ".except"}, 32'(act.except), 32'(exp_slot.except));
        check_value({name, ".exccode"}, 32'(act.exccode), 32'(exp_slot.exccode));
        check_value({name, ".badvaddr"}, act.badvaddr, exp_slot.badvaddr);
        check_value({name, ".dest"}, 32'(act.dest), 32'(exp_slot.dest));
        check_value({name, ".gr_we"}, 32'(act.gr_we), 32'(exp_slot.gr_we));
        check_value({name, ".rt_value"}, act.rt_value, exp_slot.rt_value);
    endtask

    // mostly random, sometimes a value near the signed limits
    function automatic logic [31:0] operand_value();
        logic [31:0] v;
        case (pick(8))
            0:       v = 32'h7fff_ffff;
            1:       v = 32'h8000_0000;
            2:       v = 32'hffff_ffff;
            default: v = {rand16(), rand16()};
        endcase
        return v;
    endfunction

    function automatic exe_pkg::exe_slot_in_t random_slot();
        exe_pkg::exe_slot_in_t s;
        s.pc         = {rand16(), rand16()} & 32'hffff_fffc;
        s.alu_op     = exe_pkg::alu_op_e'(4'(pick(14)));
        s.src1_sel   = exe_pkg::src1_sel_e'(2'(pick(3)));
        s.src2_sel   = exe_pkg::src2_sel_e'(2'(pick(4)));
        s.imm        = rand16();
        s.rs_value   = operand_value();
        s.rt_value   = operand_value();
        s.dest       = 5'(pick(32));
        s.gr_we      = (pick(2) == 0);
        s.ds_except  = (pick(16) == 0);
        s.ds_exccode = 5'(pick(32));
        return s;
    endfunction

    task automatic drive_inputs();
        exe_pkg::exe_pair_in_t p;
        p.inst2_valid = (pick(4) != 0);
        p.dep_rs      = (pick(3) == 0);
        p.dep_rt      = (pick(3) == 0);
        p.slot1       = random_slot();
        p.slot2       = random_slot();
        in_bus      <= p;
        in_valid    <= (pick(4) != 0);
        out_allowin <= (pick(4) != 0);
        clear       <= (pick(64) == 0);
    endtask

    // one clock edge: check what the stage showed last cycle, update the model, drive
    task automatic step_cycle();
        logic ready_now;
        logic exp_allowin;
        ready_now   = pending && (cycle - accept_cycle >= latency);
        exp_allowin = !pending || (ready_now && out_allowin);
        check_value("out_valid", 32'(out_valid), 32'(ready_now || clear));
        check_value("allowin", 32'(allowin), 32'(exp_allowin));
        if (ready_now && !clear) begin
            check_value("out_bus.inst2_valid", 32'(out_bus.inst2_valid),
                        32'(expected.inst2_valid));
            check_slot("out_bus.slot1", out_bus.slot1, expected.slot1);
            check_slot("out_bus.slot2", out_bus.slot2, expected.slot2);
        end
        idle++;
        if (clear) begin
            pending = 1'b0;
        end else if (ready_now && out_allowin) begin
            pending = 1'b0;
            pairs_done++;
            idle = 0;
        end
        if (in_valid && exp_allowin && !clear) begin
            expected     = pair_model(in_bus);
            pending      = 1'b1;
            accept_cycle = cycle;
            latency      = (in_bus.inst2_valid && (in_bus.dep_rs || in_bus.dep_rt)) ? 2 : 1;
        end
        cycle++;
        drive_inputs();
    endtask

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_bus      = '0;
        out_allowin = 1'b1;
        clear       = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (pairs_done < NUM_PAIRS) begin
            @(posedge clk);
            step_cycle();
            if (cycle > MAX_CYCLES) begin
                $display("timeout: only %0d pairs left the stage in %0d cycles",
                         pairs_done, MAX_CYCLES);
                stop_run();
            end
            if (idle > MAX_IDLE) begin
                $display("timeout: no pair left the stage for %0d cycles", MAX_IDLE);
                stop_run();
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+tests
hw/exe_pkg.sv
hw/exe_alu.sv
hw/exe_lane.sv
hw/exe_pair_ctrl.sv
hw/exe_stage.sv
tests/tb_exe_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the execute stage testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_exe_stage \
    -Mdir obj_dir -o tb_exe_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_exe_stage
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
echo "simulation finished cleanly"
exit 0
